//--- source/pipe_pkg.sv
/*
 * Shared widths, opcodes and stage packets for the four-stage ALU pipe.
 * Four 8-bit registers, 16-bit instructions, no branches or memory ops.
 * The program counter doubles as the instruction tag and wraps at 256.
 * Field order in each struct is fixed, and the testbench packs against it.
 */
`default_nettype none

package pipe_pkg;

    parameter int DATA_W  = 8;   // Register data width
    parameter int TAG_W   = 8;   // PC and tag width
    parameter int STAMP_W = 16;  // Cycle stamp width

    // 3-bit opcode field, values 6 and 7 unused
    typedef enum logic [2:0] {
        OP_NOP = 3'd0,
        OP_LI  = 3'd1,
        OP_ADD = 3'd2,
        OP_SUB = 3'd3,
        OP_AND = 3'd4,
        OP_XOR = 3'd5
    } op_e;

    // LI takes its immediate from bits 7:0, i.e. rt[0] and pad
    typedef struct packed {
        op_e        op;
        logic [1:0] rd;
        logic [1:0] rs;
        logic [1:0] rt;
        logic [6:0] pad;
    } instr_t;

    //////////////////////////////
    // Stage packets

    typedef struct packed {
        logic [TAG_W-1:0] tag;    // PC of the word
        instr_t           instr;
    } fetch_pkt_t;                // 24 bits

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        op_e               op;
        logic [1:0]        rd;
        logic [DATA_W-1:0] a;     // rs operand
        logic [DATA_W-1:0] b;     // rt operand, or immediate for LI
    } exec_pkt_t;                 // 29 bits

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [1:0]        rd;
        logic [DATA_W-1:0] data;
    } wb_pkt_t;                   // 18 bits

    typedef struct packed {
        logic [TAG_W-1:0]   tag;
        logic [STAMP_W-1:0] fetch_cycle; // First cycle the word sits in decode
        logic [STAMP_W-1:0] exec_cycle;
        logic [STAMP_W-1:0] wb_cycle;
        logic [DATA_W-1:0]  rd_data;
    } trace_rec_t;                // 64 bits

endpackage

`default_nettype wire

//--- source/pipe_stage_reg.sv
/*
 * Generic pipeline register for any packed payload.
 * hold keeps valid and data, bubble clears valid only.
 * hold and bubble must never be high together.
 * Data has no reset, only the valid bit is cleared.
 */
`timescale 1ns/10ps
`default_nettype none

module pipe_stage_reg #(
    parameter type payload_t = logic
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     hold,       // Freeze this stage
    input  wire logic     bubble,     // Insert an empty slot
    input  wire logic     in_valid,
    input  wire payload_t in_data,
    output logic          out_valid,
    output payload_t      out_data
);

    // Valid bit, the only control state here
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (bubble) begin
            out_valid <= 1'b0;        // Slot goes empty, data don't care
        end else if (!hold) begin
            out_valid <= in_valid;
        end
    end

    // Payload follows any cycle without hold
    always_ff @(posedge clk) begin
        if (!hold) begin
            out_data <= in_data;
        end
    end

    // Control from the top must keep these exclusive
    a_hold_bubble_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(hold && bubble));

    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid));

endmodule

`default_nettype wire

//--- source/fetch_stage.sv
/*
 * Program counter and instruction fetch.
 * Instruction memory is external with a combinational read,
 * imem_data must settle in the same cycle as imem_addr.
 * out_valid means the word is captured by f_reg at the next edge.
 */
`timescale 1ns/10ps
`default_nettype none

module fetch_stage (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   stall,
    output logic [pipe_pkg::TAG_W-1:0]  imem_addr,
    input  wire pipe_pkg::instr_t       imem_data,
    output logic                        out_valid,
    output pipe_pkg::fetch_pkt_t        out_pkt
);

    logic [pipe_pkg::TAG_W-1:0] pc;   // Also the tag, wraps at 256

    // PC steps once per unstalled cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!stall) begin
            pc <= pc + 1'b1;
        end
    end

    assign imem_addr = pc;

    // Word and tag go to f_reg, no stall means a capture this cycle
    assign out_valid     = !stall;
    assign out_pkt.tag   = pc;
    assign out_pkt.instr = imem_data;

    // PC must not move while the front of the pipe is frozen
    a_pc_stable: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> $stable(pc));

endmodule

`default_nettype wire

//--- source/decode_stage.sv
/*
 * Register file and decode into the execute packet.
 * Four registers, reset to 0, written at the end of the retire cycle.
 * Same-cycle writeback is bypassed to the read ports (write-through).
 * No forwarding from execute, dependents need two slots of distance.
 * Reads happen every cycle, so a held instruction picks up late writes.
 */
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   in_valid,
    input  wire pipe_pkg::fetch_pkt_t   in_pkt,
    input  wire logic                   wb_valid,   // Retire strobe
    input  wire pipe_pkg::wb_pkt_t      wb_pkt,
    output pipe_pkg::exec_pkt_t         out_pkt
);

    logic [pipe_pkg::DATA_W-1:0] regs [4];
    logic [pipe_pkg::DATA_W-1:0] rs_val;
    logic [pipe_pkg::DATA_W-1:0] rt_val;
    logic [pipe_pkg::DATA_W-1:0] imm;
    pipe_pkg::instr_t            instr;

    assign instr = in_pkt.instr;
    assign imm   = in_pkt.instr[pipe_pkg::DATA_W-1:0]; // Low byte for LI

    //////////////////////////////
    // Register file

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid) begin
            regs[wb_pkt.rd] <= wb_pkt.data;  // Retiring result lands here
        end
    end

    // Read ports with write-through
    always_comb begin
        rs_val = regs[instr.rs];
        rt_val = regs[instr.rt];
        if (wb_valid && (wb_pkt.rd == instr.rs)) rs_val = wb_pkt.data;
        if (wb_valid && (wb_pkt.rd == instr.rt)) rt_val = wb_pkt.data;
    end

    //////////////////////////////
    // Execute packet

    always_comb begin
        out_pkt = '0;                 // Empty slot decodes as NOP to r0
        if (in_valid) begin
            out_pkt.tag = in_pkt.tag;
            out_pkt.op  = instr.op;
            out_pkt.rd  = instr.rd;
            out_pkt.a   = rs_val;
            // Immediate rides on the b operand
            out_pkt.b   = (instr.op == pipe_pkg::OP_LI) ? imm : rt_val;
        end
    end

endmodule

`default_nettype wire

//--- source/execute_stage.sv
/*
 * Combinational ALU, exec packet in and writeback packet out.
 * NOP and unused opcodes give data 0 and still write rd,
 * so programs keep NOP on r0 and never read r0 as a source.
 */
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  wire pipe_pkg::exec_pkt_t in_pkt,
    output pipe_pkg::wb_pkt_t        out_pkt
);

    always_comb begin
        out_pkt.tag = in_pkt.tag;     // Tag and target pass straight on
        out_pkt.rd  = in_pkt.rd;
        case (in_pkt.op)
            pipe_pkg::OP_LI:  out_pkt.data = in_pkt.b;   // Immediate
            pipe_pkg::OP_ADD: out_pkt.data = in_pkt.a + in_pkt.b;
            pipe_pkg::OP_SUB: out_pkt.data = in_pkt.a - in_pkt.b;
            pipe_pkg::OP_AND: out_pkt.data = in_pkt.a & in_pkt.b;
            pipe_pkg::OP_XOR: out_pkt.data = in_pkt.a ^ in_pkt.b;
            default: begin
                // NOP and the two spare codes
                out_pkt.data = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/stage_tracer.sv
/*
 * Per-instruction stage tracer.
 * Table indexed by the low tag bits, TRACE_DEPTH must be a power of two
 * and at least 4, since up to 3 instructions are in flight.
 * Stamps come from a free-running counter, 0 in the first cycle after reset,
 * and wrap silently at 16 bits.
 * The record is valid in the retire cycle only.
 */
`timescale 1ns/10ps
`default_nettype none

module stage_tracer #(
    parameter int TRACE_DEPTH = 8
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   issue_valid,  // f_reg captures this cycle
    input  wire logic [pipe_pkg::TAG_W-1:0] issue_tag,
    input  wire logic                   exec_valid,   // d_reg output valid
    input  wire logic [pipe_pkg::TAG_W-1:0] exec_tag,
    input  wire logic                   retire_valid,
    input  wire pipe_pkg::wb_pkt_t      retire_pkt,
    output logic                        trace_valid,
    output pipe_pkg::trace_rec_t        trace_rec
);

    localparam int IDX_W = $clog2(TRACE_DEPTH);

    logic [pipe_pkg::STAMP_W-1:0] cycle_cnt;
    logic [pipe_pkg::STAMP_W-1:0] fetch_stamp [TRACE_DEPTH];
    logic [pipe_pkg::STAMP_W-1:0] exec_stamp  [TRACE_DEPTH];
    logic [TRACE_DEPTH-1:0]       occupied;
    logic [IDX_W-1:0]             issue_idx;
    logic [IDX_W-1:0]             exec_idx;
    logic [IDX_W-1:0]             retire_idx;

    assign issue_idx  = issue_tag[IDX_W-1:0];
    assign exec_idx   = exec_tag[IDX_W-1:0];
    assign retire_idx = retire_pkt.tag[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) cycle_cnt <= '0;
        else        cycle_cnt <= cycle_cnt + 1'b1;
    end

    //////////////////////////////
    // Stamp table

    // Fetch stamp is the cycle that opens with the word in f_reg
    always_ff @(posedge clk) begin
        if (issue_valid) fetch_stamp[issue_idx] <= cycle_cnt + 1'b1;
        if (exec_valid)  exec_stamp[exec_idx]   <= cycle_cnt;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            occupied <= '0;
        end else begin
            if (retire_valid) occupied[retire_idx] <= 1'b0;
            if (issue_valid)  occupied[issue_idx]  <= 1'b1;  // Set wins
        end
    end

    //////////////////////////////
    // Retire record

    assign trace_valid = retire_valid;

    always_comb begin
        trace_rec.tag         = retire_pkt.tag;
        trace_rec.fetch_cycle = fetch_stamp[retire_idx];
        trace_rec.exec_cycle  = exec_stamp[retire_idx];
        trace_rec.wb_cycle    = cycle_cnt;          // Retire happens now
        trace_rec.rd_data     = retire_pkt.data;
    end

    // Entry lifetime must fit in the table
    a_occ_at_retire: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> occupied[retire_idx]);

    a_free_at_issue: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> !occupied[issue_idx]);

endmodule

`default_nettype wire

//--- source/alu_pipe_top.sv
/*
 * Four-stage ALU pipe with tracer: fetch, decode, execute, writeback.
 * stall freezes PC and f_reg and drops a bubble into d_reg,
 * the back of the pipe keeps draining.
 * No hazard checks, program order must space dependents two slots.
 */
`timescale 1ns/10ps
`default_nettype none

module alu_pipe_top #(
    parameter int TRACE_DEPTH = 8
) (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   stall,
    output logic [pipe_pkg::TAG_W-1:0]  imem_addr,
    input  wire pipe_pkg::instr_t       imem_data,
    output logic                        retire_valid,  // Writeback strobe
    output pipe_pkg::wb_pkt_t           retire_pkt,
    output logic                        trace_valid,
    output pipe_pkg::trace_rec_t        trace_rec
);

    logic                 fetch_valid;
    pipe_pkg::fetch_pkt_t fetch_pkt;
    logic                 dec_valid;      // f_reg output, decode slot
    pipe_pkg::fetch_pkt_t dec_in_pkt;
    pipe_pkg::exec_pkt_t  dec_pkt;
    logic                 ex_valid;       // d_reg output, execute slot
    pipe_pkg::exec_pkt_t  ex_in_pkt;
    pipe_pkg::wb_pkt_t    ex_pkt;

    fetch_stage u_fetch (
        .clk(clk), .rst_n(rst_n), .stall(stall),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .out_valid(fetch_valid), .out_pkt(fetch_pkt)
    );

    pipe_stage_reg #(.payload_t(pipe_pkg::fetch_pkt_t)) f_reg (
        .clk(clk), .rst_n(rst_n), .hold(stall), .bubble(1'b0),
        .in_valid(fetch_valid), .in_data(fetch_pkt),
        .out_valid(dec_valid), .out_data(dec_in_pkt)
    );

    decode_stage u_decode (
        .clk(clk), .rst_n(rst_n), .in_valid(dec_valid), .in_pkt(dec_in_pkt),
        .wb_valid(retire_valid), .wb_pkt(retire_pkt), .out_pkt(dec_pkt)
    );

    // Stalled decode leaves an empty slot behind it
    pipe_stage_reg #(.payload_t(pipe_pkg::exec_pkt_t)) d_reg (
        .clk(clk), .rst_n(rst_n), .hold(1'b0), .bubble(stall),
        .in_valid(dec_valid), .in_data(dec_pkt),
        .out_valid(ex_valid), .out_data(ex_in_pkt)
    );

    execute_stage u_execute (.in_pkt(ex_in_pkt), .out_pkt(ex_pkt));

    pipe_stage_reg #(.payload_t(pipe_pkg::wb_pkt_t)) e_reg (
        .clk(clk), .rst_n(rst_n), .hold(1'b0), .bubble(1'b0),
        .in_valid(ex_valid), .in_data(ex_pkt),
        .out_valid(retire_valid), .out_data(retire_pkt)
    );

    stage_tracer #(.TRACE_DEPTH(TRACE_DEPTH)) u_tracer (
        .clk(clk), .rst_n(rst_n),
        .issue_valid(fetch_valid), .issue_tag(fetch_pkt.tag),
        .exec_valid(ex_valid), .exec_tag(ex_in_pkt.tag),
        .retire_valid(retire_valid), .retire_pkt(retire_pkt),
        .trace_valid(trace_valid), .trace_rec(trace_rec)
    );

endmodule

`default_nettype wire

//--- tests/alu_pipe_tb.sv
/*
 * Testbench for the four-stage ALU pipe and its tracer.
 * Instruction memory is a 256-word array read combinationally at imem_addr.
 * Random programs keep dependents two slots apart and never read r0.
 * Expected timing comes from the capture cycles seen here. A word captured
 * in cycle C sits in decode from C+1 and retires two cycles after the
 * next capture. Stalls are only driven while a counted word sits in decode.
 */
`timescale 1ns/10ps
`default_nettype none

module alu_pipe_tb;

    localparam int          CLK_HALF = 20;              // 40 ns period
    localparam logic [31:0] SEED     = 32'hb3f2_5d92;

    logic                         clk;
    logic                         rst_n;
    logic                         stall;
    logic [pipe_pkg::TAG_W-1:0]   imem_addr;
    pipe_pkg::instr_t             imem_data;
    logic                         retire_valid;
    pipe_pkg::wb_pkt_t            retire_pkt;
    logic                         trace_valid;
    pipe_pkg::trace_rec_t         trace_rec;

    pipe_pkg::instr_t             imem [256];
    logic [pipe_pkg::STAMP_W-1:0] cycle_now;            // Mirrors the tracer counter
    int                           checks;
    int                           errors;

    alu_pipe_top #(.TRACE_DEPTH(8)) u_dut (
        .clk(clk), .rst_n(rst_n), .stall(stall),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .retire_valid(retire_valid), .retire_pkt(retire_pkt),
        .trace_valid(trace_valid), .trace_rec(trace_rec)
    );

    assign imem_data = imem[imem_addr];   // Same-cycle read

    always #CLK_HALF clk = ~clk;

    //////////////////////////////
    // Compare tasks

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_tag(input string name, input logic [pipe_pkg::TAG_W-1:0] exp,
                             input logic [pipe_pkg::TAG_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_stamp(input string name, input logic [pipe_pkg::STAMP_W-1:0] exp,
                               input logic [pipe_pkg::STAMP_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_wb(input string name, input pipe_pkg::wb_pkt_t exp,
                            input pipe_pkg::wb_pkt_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $write("CHECK FAILED %s: expected tag=%0d rd=%0d data=%02h, ",
                   name, exp.tag, exp.rd, exp.data);
            $display("actual tag=%0d rd=%0d data=%02h", act.tag, act.rd, act.data);
        end
    endtask

    task automatic check_trace(input string name, input pipe_pkg::trace_rec_t exp,
                               input pipe_pkg::trace_rec_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("CHECK FAILED %s: expected tag=%0d f=%0d e=%0d w=%0d d=%02h",
                     name, exp.tag, exp.fetch_cycle, exp.exec_cycle, exp.wb_cycle, exp.rd_data);
            $display("    actual tag=%0d f=%0d e=%0d w=%0d d=%02h",
                     act.tag, act.fetch_cycle, act.exec_cycle, act.wb_cycle, act.rd_data);
        end
    endtask

    //////////////////////////////
    // Reset and program setup

    // Leaves the testbench at the falling edge of cycle 0
    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        stall = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n     = 1'b1;
        cycle_now = '0;                   // First cycle after release
    endtask

    // Random program over all 256 words with a NOP in the last word to keep the wrap spaced
    task automatic load_program();
        pipe_pkg::instr_t ins;
        logic [1:0]       prev_rd;
        prev_rd = 2'd0;
        for (int a = 0; a < 256; a++) begin
            ins    = '0;
            ins.op = pipe_pkg::op_e'(3'($urandom_range(5)));
            if (a == 255) ins.op = pipe_pkg::OP_NOP;
            if (ins.op != pipe_pkg::OP_NOP) ins.rd = 2'($urandom_range(3, 1));  // NOP keeps r0
            if (ins.op == pipe_pkg::OP_LI) begin
                ins[7:0] = 8'($urandom);      // Immediate in the low byte
            end else if (ins.op != pipe_pkg::OP_NOP) begin
                // Sources skip r0 and the previous destination
                do begin
                    ins.rs = 2'($urandom_range(3, 1));
                end while (ins.rs == prev_rd);
                do begin
                    ins.rt = 2'($urandom_range(3, 1));
                end while (ins.rt == prev_rd);
            end
            imem[a] = ins;
            prev_rd = ins.rd;
        end
    endtask

    //////////////////////////////
    // Program run with reference model

    task automatic run_program(input string name, input int n, input int stall_pct);
        logic [pipe_pkg::DATA_W-1:0]  mregs [4];    // Reference register file
        logic [pipe_pkg::STAMP_W-1:0] cap_q [$];    // Cycle of each capture
        logic [pipe_pkg::STAMP_W-1:0] prev_wb;
        logic [pipe_pkg::STAMP_W-1:0] delay;
        logic [pipe_pkg::DATA_W-1:0]  data;
        pipe_pkg::instr_t             ins;
        pipe_pkg::wb_pkt_t            exp_wb;
        pipe_pkg::trace_rec_t         exp_rec;
        logic                         exp_retire;
        int                           retired;
        int                           stall_left;
        int                           stall_cycles;
        int                           delay_sum;
        int                           cycles;
        retired      = 0;
        stall_left   = 0;
        stall_cycles = 0;
        delay_sum    = 0;
        cycles       = 0;
        prev_wb      = '0;
        for (int r = 0; r < 4; r++) begin
            mregs[r] = '0;
        end
        apply_reset();
        while (retired < n && cycles < 4 * n + 100) begin
            // Word k retires two cycles after capture k+1
            exp_retire = (cap_q.size() > retired + 1) &&
                         (cap_q[retired + 1] + 16'd2 == cycle_now);
            check_flag({name, " retire_valid"}, exp_retire, retire_valid);
            check_flag({name, " trace_valid"}, exp_retire, trace_valid);
            if (retire_valid) begin
                ins = imem[retired[pipe_pkg::TAG_W-1:0]];
                case (ins.op)
                    pipe_pkg::OP_LI:  data = ins[7:0];
                    pipe_pkg::OP_ADD: data = mregs[ins.rs] + mregs[ins.rt];
                    pipe_pkg::OP_SUB: data = mregs[ins.rs] - mregs[ins.rt];
                    pipe_pkg::OP_AND: data = mregs[ins.rs] & mregs[ins.rt];
                    pipe_pkg::OP_XOR: data = mregs[ins.rs] ^ mregs[ins.rt];
                    default:          data = '0;
                endcase
                mregs[ins.rd] = data;
                exp_wb.tag  = retired[pipe_pkg::TAG_W-1:0];   // PC modulo 256
                exp_wb.rd   = ins.rd;
                exp_wb.data = data;
                check_wb(name, exp_wb, retire_pkt);
                exp_rec.tag         = exp_wb.tag;
                exp_rec.fetch_cycle = cap_q[retired] + 16'd1;
                exp_rec.exec_cycle  = cap_q[retired + 1] + 16'd1;
                exp_rec.wb_cycle    = cap_q[retired + 1] + 16'd2;
                exp_rec.rd_data     = data;
                check_trace(name, exp_rec, trace_rec);
                check_stamp({name, " wb after exec"}, trace_rec.exec_cycle + 16'd1,
                            trace_rec.wb_cycle);
                if (stall_pct == 0) begin
                    check_stamp({name, " exec after fetch"}, trace_rec.fetch_cycle + 16'd1,
                                trace_rec.exec_cycle);
                    if (retired > 0) begin
                        check_stamp({name, " wb spacing"}, prev_wb + 16'd1, trace_rec.wb_cycle);
                    end
                end
                delay     = trace_rec.exec_cycle - trace_rec.fetch_cycle - 16'd1;
                delay_sum += int'(delay);
                prev_wb   = trace_rec.wb_cycle;
                retired++;
            end
            // Stall runs only while a counted word is held in decode
            if (stall_left == 0 && stall_pct > 0 && $urandom_range(99) < stall_pct) begin
                stall_left = 1 + $urandom_range(3);
            end
            if (cap_q.size() < 3 || cap_q.size() >= n) stall_left = 0;
            stall = (stall_left > 0);
            if (stall) begin
                stall_left--;
                stall_cycles++;
            end else begin
                cap_q.push_back(cycle_now);   // f_reg captures at this edge
            end
            @(posedge clk);
            cycle_now++;
            cycles++;
            @(negedge clk);
        end
        stall = 1'b0;
        if (retired < n) begin
            errors++;
            $display("ERROR %s: timed out, only %0d of %0d instructions retired",
                     name, retired, n);
        end
        if (stall_pct > 0) begin
            check_stamp({name, " stall total"}, stall_cycles[pipe_pkg::STAMP_W-1:0],
                        delay_sum[pipe_pkg::STAMP_W-1:0]);
        end
    endtask

    //////////////////////////////
    // Directed tests

    // Second round resets with the pipe full
    task automatic reset_clears_outputs();
        for (int round = 0; round < 2; round++) begin
            apply_reset();
            check_flag("reset retire_valid", 1'b0, retire_valid);
            check_flag("reset trace_valid", 1'b0, trace_valid);
            check_tag("reset imem_addr", 8'd0, imem_addr);
            repeat (6) @(negedge clk);
        end
    endtask

    task automatic arith_without_stall();
        load_program();
        run_program("arith", 80, 0);
    endtask

    task automatic results_under_stall();
        load_program();
        run_program("stall", 150, 30);
    endtask

    task automatic tag_wraparound();
        load_program();
        run_program("wrap", 300, 10);    // Past the tag wrap at 256
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        stall     = 1'b0;
        cycle_now = '0;
        checks    = 0;
        errors    = 0;
        void'($urandom(SEED));
        load_program();
        reset_clears_outputs();
        arith_without_stall();
        results_under_stall();
        tag_wraparound();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
source/pipe_pkg.sv
source/pipe_stage_reg.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/stage_tracer.sv
source/alu_pipe_top.sv
tests/alu_pipe_tb.sv

//--- Makefile
# Verilator build and run for the ALU pipe testbench

VERILATOR  ?= verilator
TOP        := alu_pipe_tb
FLIST      := flist.f
FLAGS      := --binary --timing --assert -Mdir obj_dir
LINT_FLAGS := --lint-only --timing
BIN        := obj_dir/V$(TOP)
PASS_MSG   := RESULT: PASS

.PHONY: all run lint clean

all: run

$(BIN): $(FLIST) $(wildcard source/*.sv tests/*.sv)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

# The run passes only if the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir
